//--- source/mc_settings.svh
// width, count and depth settings for the memory-side frontend
// shared by the package, the RTL and the testbench

`ifndef MC_SETTINGS_SVH
`define MC_SETTINGS_SVH

// wormhole lanes, two vertical sides times the ruche factor
`define MC_NUM_WH_LANES        4
`define MC_WH_RUCHE_FACTOR     2
`define MC_LG_WH_RUCHE_FACTOR  1

// header flit layout
`define MC_WH_FLIT_WIDTH       32
`define MC_WH_CORD_WIDTH       8
`define MC_FLIT_ADDR_WIDTH     23

// remapped dma address and test memory geometry
`define MC_DMA_ADDR_WIDTH      28
`define MC_LG_MEM_SIZE         20
`define MC_LG_NUM_VCACHES      2

// boot sequencing
`define MC_TAG_PROG_CYCLES     16
`define MC_RESET_DEPTH         3
`define MC_CYCLE_CTR_WIDTH     64

`endif

//--- source/mc_pkg.sv
// shared types for the memory-side frontend
// header flit, dma packet and core cycle counter

`default_nettype none

`include "mc_settings.svh"

package mc_pkg;

  // wormhole header flit, msb first
  typedef struct packed {
    logic [`MC_WH_CORD_WIDTH-1:0]   src_cord;
    logic                           write_not_read;
    logic [`MC_FLIT_ADDR_WIDTH-1:0] addr;
  } wh_flit_t;

  // request toward the test memory
  typedef struct packed {
    logic                          write_not_read;
    logic [`MC_DMA_ADDR_WIDTH-1:0] addr;
  } dma_pkt_t;

  // free running core cycle count
  typedef logic [`MC_CYCLE_CTR_WIDTH-1:0] cycle_ctr_t;

endpackage

`default_nettype wire

//--- source/mc_pipe_reg.sv
// delay chain of DEPTH stages for any payload type
// plain flops, no reset and no enable

`timescale 1ns/1ns
`default_nettype none

module mc_pipe_reg #(
  parameter type data_t = logic,
  parameter int  DEPTH  = 1
) (
  input  logic  clk_i,
  input  data_t data_i,
  output data_t data_o
);

  data_t stage_r [DEPTH];

  if (DEPTH < 1) begin : g_bad_depth
    $error("mc_pipe_reg needs at least one stage");
  end

  always_ff @(posedge clk_i) begin
    stage_r[0] <= data_i;
    // shift toward the last stage
    for (int i = 1; i < DEPTH; i++) begin
      stage_r[i] <= stage_r[i-1];
    end
  end

  assign data_o = stage_r[DEPTH-1];

endmodule

`default_nettype wire

//--- source/mc_boot_ctl.sv
// boot sequencing: tag programming counter, core reset chain
// and the core cycle counter

`timescale 1ns/1ns
`default_nettype none

`include "mc_settings.svh"

module mc_boot_ctl
  import mc_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  output logic       tag_done_o,
  output logic       core_reset_o,
  output cycle_ctr_t cycle_ctr_o
);

  localparam int TAG_CNT_W = $clog2(`MC_TAG_PROG_CYCLES + 1);

  logic [TAG_CNT_W-1:0] tag_cnt_r;
  logic                 chain_in;
  cycle_ctr_t           cycle_ctr_r;

  // tag programming, counts up once and parks at the limit
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tag_cnt_r <= '0;
    end else if (!tag_done_o) begin
      tag_cnt_r <= tag_cnt_r + 1'b1;
    end
  end

  assign tag_done_o = (tag_cnt_r == TAG_CNT_W'(`MC_TAG_PROG_CYCLES));

  // core held in reset until programming is done
  assign chain_in = reset_i | ~tag_done_o;

  mc_pipe_reg #(
    .data_t (logic),
    .DEPTH  (`MC_RESET_DEPTH)
  ) reset_chain (
    .clk_i  (clk_i),
    .data_i (chain_in),
    .data_o (core_reset_o)
  );

  // zero in the first cycle out of core reset
  always_ff @(posedge clk_i) begin
    if (core_reset_o) begin
      cycle_ctr_r <= '0;
    end else begin
      cycle_ctr_r <= cycle_ctr_r + 1'b1;
    end
  end

  assign cycle_ctr_o = cycle_ctr_r;

  // done only drops through a host reset
  tag_done_sticky: assert property (
    @(posedge clk_i) $fell(tag_done_o) |-> $past(reset_i)
  ) else $error("tag_done_o fell without reset_i");

endmodule

`default_nettype wire

//--- source/mc_wh_dma_remap.sv
// one wormhole lane toward the test memory
// undoes ruche inversion, unpacks the header flit, splices the
// vcache index into the dma address and registers the packet

`timescale 1ns/1ns
`default_nettype none

`include "mc_settings.svh"

module mc_wh_dma_remap
  import mc_pkg::*;
#(
  parameter bit LANE_ODD = 1'b0
) (
  input  logic                         clk_i,
  input  logic                         core_reset_i,
  input  logic [`MC_WH_FLIT_WIDTH-1:0] wh_flit_i,
  input  logic                         wh_v_i,
  output dma_pkt_t                     dma_pkt_o,
  output logic                         dma_pkt_v_o
);

  // address field split
  localparam int LOW_W = `MC_LG_MEM_SIZE - `MC_LG_NUM_VCACHES;
  localparam int PAD_W = `MC_DMA_ADDR_WIDTH - `MC_LG_MEM_SIZE;

  logic [`MC_WH_FLIT_WIDTH-1:0] flit_restored;
  wh_flit_t                     flit;
  dma_pkt_t                     pkt_remap;
  logic                         pkt_v_r;

  // odd ruche lanes travel inverted
  assign flit_restored = LANE_ODD ? ~wh_flit_i : wh_flit_i;
  assign flit          = wh_flit_t'(flit_restored);

  // {zeros, vcache index from source cord, low address bits}
  assign pkt_remap.write_not_read = flit.write_not_read;
  assign pkt_remap.addr = {
    {PAD_W{1'b0}},
    flit.src_cord[`MC_LG_WH_RUCHE_FACTOR +: `MC_LG_NUM_VCACHES],
    flit.addr[0 +: LOW_W]
  };

  mc_pipe_reg #(
    .data_t (dma_pkt_t),
    .DEPTH  (1)
  ) pkt_reg (
    .clk_i  (clk_i),
    .data_i (pkt_remap),
    .data_o (dma_pkt_o)
  );

  always_ff @(posedge clk_i) begin
    if (core_reset_i) begin
      pkt_v_r <= 1'b0;
    end else begin
      pkt_v_r <= wh_v_i;
    end
  end

  assign dma_pkt_v_o = pkt_v_r;

  // nothing leaves the lane right after core reset
  no_pkt_after_reset: assert property (
    @(posedge clk_i) $past(core_reset_i) |-> !dma_pkt_v_o
  ) else $error("dma_pkt_v_o high after core reset");

  // a valid packet carries a known payload
  pkt_known: assert property (
    @(posedge clk_i) dma_pkt_v_o |-> !$isunknown(dma_pkt_o)
  ) else $error("dma_pkt_o unknown while valid");

endmodule

`default_nettype wire

//--- source/mc_mem_frontend.sv
// memory-side frontend top: boot control plus one dma remapper
// per wormhole lane

`timescale 1ns/1ns
`default_nettype none

`include "mc_settings.svh"

module mc_mem_frontend
  import mc_pkg::*;
(
  input  logic                                                 clk_i,
  input  logic                                                 reset_i,
  output logic                                                 tag_done_o,
  output logic                                                 core_reset_o,
  output cycle_ctr_t                                           cycle_ctr_o,
  input  logic [`MC_NUM_WH_LANES-1:0][`MC_WH_FLIT_WIDTH-1:0]   wh_flit_i,
  input  logic [`MC_NUM_WH_LANES-1:0]                          wh_v_i,
  output dma_pkt_t [`MC_NUM_WH_LANES-1:0]                      dma_pkt_o,
  output logic [`MC_NUM_WH_LANES-1:0]                          dma_pkt_v_o
);

  logic core_reset;

  mc_boot_ctl boot (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .tag_done_o   (tag_done_o),
    .core_reset_o (core_reset),
    .cycle_ctr_o  (cycle_ctr_o)
  );

  assign core_reset_o = core_reset;

  // ruche index is lane modulo the ruche factor
  for (genvar l = 0; l < `MC_NUM_WH_LANES; l++) begin : g_lane
    mc_wh_dma_remap #(
      .LANE_ODD (((l % `MC_WH_RUCHE_FACTOR) % 2) == 1)
    ) remap (
      .clk_i        (clk_i),
      .core_reset_i (core_reset),
      .wh_flit_i    (wh_flit_i[l]),
      .wh_v_i       (wh_v_i[l]),
      .dma_pkt_o    (dma_pkt_o[l]),
      .dma_pkt_v_o  (dma_pkt_v_o[l])
    );
  end

endmodule

`default_nettype wire

//--- tests/tb_mc_model.svh
// reference model for the memory-side frontend testbench
// lane restore, flit remap, boot timing and the compare task

`ifndef TB_MC_MODEL_SVH
`define TB_MC_MODEL_SVH

localparam int FLIT_W    = `MC_WH_FLIT_WIDTH;
localparam int CORD_W    = `MC_WH_CORD_WIDTH;
localparam int ADDR_W    = `MC_FLIT_ADDR_WIDTH;
localparam int VC_W      = `MC_LG_NUM_VCACHES;
localparam int LOW_W     = `MC_LG_MEM_SIZE - `MC_LG_NUM_VCACHES;
localparam int DMA_PKT_W = `MC_DMA_ADDR_WIDTH + 1;
localparam int BOOT_EDGES = `MC_TAG_PROG_CYCLES + `MC_RESET_DEPTH;

// odd ruche index means the lane arrives inverted
function automatic logic [FLIT_W-1:0] restore_flit(input int lane,
                                                   input logic [FLIT_W-1:0] raw);
  if (((lane % `MC_WH_RUCHE_FACTOR) % 2) == 1) begin
    return ~raw;
  end
  return raw;
endfunction

function automatic logic [DMA_PKT_W-1:0] remap_flit(input logic [FLIT_W-1:0] flit);
  logic [CORD_W-1:0]             cord;
  logic                          wnr;
  logic [ADDR_W-1:0]             addr;
  logic [`MC_DMA_ADDR_WIDTH-1:0] dma_addr;
  cord = flit[FLIT_W-1 -: CORD_W];
  wnr  = flit[ADDR_W];
  addr = flit[ADDR_W-1:0];
  dma_addr = '0;
  dma_addr[LOW_W-1:0] = addr[LOW_W-1:0];
  // vcache index sits right above the low address bits
  dma_addr[LOW_W +: VC_W] = cord[`MC_LG_WH_RUCHE_FACTOR +: VC_W];
  return {wnr, dma_addr};
endfunction

// n counts rising edges that sampled reset_i low
function automatic logic exp_tag_done(input int n);
  return n >= `MC_TAG_PROG_CYCLES;
endfunction

function automatic logic exp_core_reset(input int n);
  return n < BOOT_EDGES;
endfunction

function automatic logic [63:0] exp_cycle_ctr(input int n);
  return (n >= BOOT_EDGES) ? 64'(n - BOOT_EDGES) : 64'd0;
endfunction

task automatic check_equal(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
  if (actual !== expected) begin
    err_count++;
    $display("ERR %s expected 0x%h actual 0x%h", name, expected, actual);
  end
endtask

`endif

//--- tests/tb_mc_mem_frontend.sv
// testbench for the memory-side frontend
// boot sequencing and random traffic on all lanes against a model

`timescale 1ns/1ns
`default_nettype none

`include "mc_settings.svh"

module tb_mc_mem_frontend
  import mc_pkg::*;
();

  localparam int CLK_PERIOD     = 100;
  localparam int DRIVE_DELAY    = 10;
  localparam int RESET_CYCLES   = 10;
  localparam int TRAFFIC_CYCLES = 400;
  localparam int LANES          = `MC_NUM_WH_LANES;
  localparam int RUN_CYCLES     = `MC_TAG_PROG_CYCLES + `MC_RESET_DEPTH + TRAFFIC_CYCLES;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + RUN_CYCLES + 50;

  logic                                         clk_i;
  logic                                         reset_i;
  logic                                         tag_done_o;
  logic                                         core_reset_o;
  cycle_ctr_t                                   cycle_ctr_o;
  logic [LANES-1:0][`MC_WH_FLIT_WIDTH-1:0]      wh_flit_i;
  logic [LANES-1:0]                             wh_v_i;
  dma_pkt_t [LANES-1:0]                         dma_pkt_o;
  logic [LANES-1:0]                             dma_pkt_v_o;

  integer seed        = 36227;
  int     err_count   = 0;
  int     pkt_count   = 0;
  int     reset_flits = 0;
  int     cycle_count = 0;

  // lane inputs of the previous cycle, as seen by the next edge
  logic                         prev_v    [LANES];
  logic [`MC_WH_FLIT_WIDTH-1:0] prev_flit [LANES];
  logic                         prev_core_reset;

  `include "tb_mc_model.svh"

  mc_mem_frontend dut0 (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .tag_done_o   (tag_done_o),
    .core_reset_o (core_reset_o),
    .cycle_ctr_o  (cycle_ctr_o),
    .wh_flit_i    (wh_flit_i),
    .wh_v_i       (wh_v_i),
    .dma_pkt_o    (dma_pkt_o),
    .dma_pkt_v_o  (dma_pkt_v_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // about 60 percent valid per lane, random flit
  task automatic drive_lanes(input logic core_reset_exp);
    for (int l = 0; l < LANES; l++) begin
      wh_v_i[l]    = ({$random(seed)} % 100) < 60;
      wh_flit_i[l] = $random(seed);
      prev_v[l]    = wh_v_i[l];
      prev_flit[l] = wh_flit_i[l];
      if (wh_v_i[l] && core_reset_exp) begin
        reset_flits++;
      end
    end
    prev_core_reset = core_reset_exp;
  endtask

  task automatic check_boot(input int n);
    check_equal("tag_done_o", 64'(exp_tag_done(n)), 64'(tag_done_o));
    check_equal("core_reset_o", 64'(exp_core_reset(n)), 64'(core_reset_o));
    check_equal("cycle_ctr_o", exp_cycle_ctr(n), cycle_ctr_o);
  endtask

  task automatic check_lanes();
    logic exp_v;
    for (int l = 0; l < LANES; l++) begin
      exp_v = prev_v[l] && !prev_core_reset;
      check_equal($sformatf("dma_pkt_v_o[%0d]", l), 64'(exp_v), 64'(dma_pkt_v_o[l]));
      if (exp_v) begin
        check_equal($sformatf("dma_pkt_o[%0d]", l),
                    64'(remap_flit(restore_flit(l, prev_flit[l]))), 64'(dma_pkt_o[l]));
      end
      if (dma_pkt_v_o[l] === 1'b1) begin
        pkt_count++;
      end
    end
  endtask

  initial begin
    reset_i   = 1'b1;
    wh_v_i    = '0;
    wh_flit_i = '0;
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      if (i == RESET_CYCLES - 1) begin
        reset_i = 1'b0;
      end
      drive_lanes(1'b1);
    end
    // n = 0 is the state right after the last reset edge
    check_boot(0);
    for (int n = 1; n <= RUN_CYCLES; n++) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      check_boot(n);
      check_lanes();
      drive_lanes(exp_core_reset(n));
    end
    if (pkt_count == 0) begin
      err_count++;
      $display("no packets were received after core reset");
    end
    $display("errors: %0d  packets received: %0d  flits during core reset: %0d",
             err_count, pkt_count, reset_flits);
    if (err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the run did not finish", cycle_count);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+source
+incdir+tests
source/mc_pkg.sv
source/mc_pipe_reg.sv
source/mc_boot_ctl.sv
source/mc_wh_dma_remap.sv
source/mc_mem_frontend.sv
tests/tb_mc_mem_frontend.sv

//--- Bender.yml
package:
  name: mc_mem_frontend

export_include_dirs:
  - source

sources:
  - source/mc_pkg.sv
  - source/mc_pipe_reg.sv
  - source/mc_boot_ctl.sv
  - source/mc_wh_dma_remap.sv
  - source/mc_mem_frontend.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_mc_mem_frontend.sv
